//--- vid_pkg.sv
/*
 * Video mode package
 * Dimension width, size and pixel types, and the lock-state
 * encoding shared by the sync-to-stream converter
 */
`default_nettype none

package vid_pkg;

	////////////////////
	// Widths
	////////////////////

	// Bits in one measured dimension
	localparam int DIM_W = 16;
	// RGB, 8 bits per colour
	localparam int PIXEL_W = 24;

	////////////////////
	// Types
	////////////////////

	// Size in clocks or lines
	typedef logic [DIM_W-1:0] dim_t;
	// Running count, top bit marks saturation
	typedef logic [DIM_W:0] cnt_t;
	// One RGB pixel
	typedef logic [PIXEL_W-1:0] pixel_t;

	// Lock progress, horizontal first
	typedef enum logic [1:0] {
		UNLOCKED = 2'd0,
		H_LOCKED = 2'd1,
		LOCKED   = 2'd2
	} lock_state_t;

endpackage

`default_nettype wire

//--- vid_sync_detect.sv
/*
 * Sync detection for raster video input
 * Learns both sync polarities, finds normalized hsync edges and
 * emits the row, line and frame event strobes for the counters
 */
`timescale 1ns/1ps
`default_nettype none

module vid_sync_detect (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_pix_valid,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_row_start,
	output logic o_row_meas,
	output logic o_line_start,
	output logic o_frame_start,
	output logic o_line_had_pixels,
	output logic o_pix_in_row,
	output logic o_hpol,
	output logic o_vpol
);

	logic       hsync_n;
	logic       last_pv;
	logic       last_hs;
	logic       hs_rise;
	logic       line_edge;
	logic [1:0] hs_edges;
	logic       has_pixels;

	////////////////////
	// Edge detection
	////////////////////

	// Normalized hsync, active high once polarity is known
	assign hsync_n = o_hpol ^ i_hsync;
	assign hs_rise = hsync_n && !last_hs;
	// Line boundary only counts outside the active pixels
	assign line_edge = hs_rise && !last_pv;

	// First pixel of a row
	assign o_row_start = i_pix_valid && !last_pv;
	// Two sync edges since the last row start means an empty row
	assign o_row_meas = o_row_start && (hs_edges != 2'd2);
	// Horizontal counter qualifier, in step with row_start
	assign o_pix_in_row = i_pix_valid;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			last_pv <= 1'b0;
			last_hs <= 1'b0;
		end
		else
		begin
			last_pv <= i_pix_valid;
			last_hs <= hsync_n;
		end
	end

	// Sync levels right after the pixels are the inactive levels
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			// Assume inverted until a row shows otherwise
			o_hpol <= 1'b1;
			o_vpol <= 1'b1;
		end
		else if (last_pv && !i_pix_valid)
		begin
			o_hpol <= i_hsync;
			o_vpol <= i_vsync;
		end
	end

	// Sync edges since the last row start, saturating at two
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			// No measured row yet, so the first row start is skipped
			hs_edges <= 2'd2;
		else if (o_row_start)
			hs_edges <= 2'd0;
		else if (hs_rise && (hs_edges != 2'd2))
			hs_edges <= hs_edges + 2'd1;
	end

	////////////////////
	// Line and frame events
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_line_start      <= 1'b0;
			o_frame_start     <= 1'b0;
			o_line_had_pixels <= 1'b0;
			has_pixels        <= 1'b0;
		end
		else if (line_edge)
		begin
			o_line_start      <= 1'b1;
			// First line with pixels after one without
			o_frame_start     <= has_pixels && !o_line_had_pixels;
			o_line_had_pixels <= has_pixels;
			has_pixels        <= 1'b0;
		end
		else
		begin
			o_line_start  <= 1'b0;
			o_frame_start <= 1'b0;
			if (i_pix_valid)
				has_pixels <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- vid_span_counter.sv
/*
 * Span counter
 * Total and active counts of one axis, both saturating,
 * restarted and stepped by event strobes
 */
`timescale 1ns/1ps
`default_nettype none

module vid_span_counter (
	input  logic          i_clk,
	input  logic          i_restart,
	input  logic          i_step,
	input  logic          i_active,
	output vid_pkg::cnt_t o_total,
	output vid_pkg::cnt_t o_active
);

	import vid_pkg::*;

	// Restart counts the current clock or line as the first one
	always_ff @(posedge i_clk)
	begin
		if (i_restart)
		begin
			o_total  <= cnt_t'(1);
			o_active <= cnt_t'(1);
		end
		else if (i_step)
		begin
			// Hold once the top bit is set
			if (!o_total[DIM_W])
				o_total <= o_total + cnt_t'(1);
			// Active span only grows inside the active region
			if (i_active && !o_active[DIM_W])
				o_active <= o_active + cnt_t'(1);
		end
	end

endmodule

`default_nettype wire

//--- vid_mode_capture.sv
/*
 * Mode capture for one axis
 * Latches the measured active and total sizes and flags, one
 * clock later, whether they repeat the previous capture
 */
`timescale 1ns/1ps
`default_nettype none

module vid_mode_capture (
	input  logic          i_clk,
	input  logic          i_reset,
	input  logic          i_capture,
	input  vid_pkg::cnt_t i_active,
	input  vid_pkg::cnt_t i_total,
	output vid_pkg::dim_t o_active,
	output vid_pkg::dim_t o_total,
	output logic          o_same,
	output logic          o_differ
);

	import vid_pkg::*;

	logic in_sat;
	logic in_match;

	// Either count ran past the dimension width
	assign in_sat = i_active[DIM_W] || i_total[DIM_W];

	// Compare against the values held from the last capture
	assign in_match = (i_active[DIM_W-1:0] == o_active)
		&& (i_total[DIM_W-1:0] == o_total);

	////////////////////
	// Capture registers
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_active <= '0;
			o_total  <= '0;
			o_same   <= 1'b0;
			o_differ <= 1'b0;
		end
		else
		begin
			// Verdict strobes last a single clock
			o_same   <= 1'b0;
			o_differ <= 1'b0;
			if (i_capture)
			begin
				o_active <= i_active[DIM_W-1:0];
				o_total  <= i_total[DIM_W-1:0];
				if (in_match && !in_sat)
					o_same <= 1'b1;
				else
					o_differ <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- vid_lock_fsm.sv
/*
 * Lock FSM
 * Horizontal lock first, then full lock once the frame sizes
 * repeat, with a fall back on any differing capture
 */
`timescale 1ns/1ps
`default_nettype none

module vid_lock_fsm (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_h_same,
	input  logic i_h_differ,
	input  logic i_v_same,
	input  logic i_v_differ,
	output logic o_locked
);

	import vid_pkg::*;

	lock_state_t state;
	lock_state_t state_next;

	////////////////////
	// Next state
	////////////////////

	always_comb
	begin
		state_next = state;
		// A new line width undoes everything
		if (i_h_differ)
			state_next = UNLOCKED;
		else
		begin
			case (state)
				UNLOCKED:
				begin
					if (i_h_same)
						state_next = H_LOCKED;
				end
				H_LOCKED:
				begin
					// Needs two matching frames in a row
					if (i_v_same)
						state_next = LOCKED;
				end
				LOCKED:
				begin
					// Frame size changed, line size still good
					if (i_v_differ)
						state_next = H_LOCKED;
				end
				default:
					state_next = UNLOCKED;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= UNLOCKED;
		else
			state <= state_next;
	end

	assign o_locked = (state == LOCKED);

endmodule

`default_nettype wire

//--- vid_stream_out.sv
/*
 * Pixel stream output
 * Forwards each pixel one clock later, marking the last pixel
 * of a line on tuser and the last pixel of a frame on tlast
 */
`timescale 1ns/1ps
`default_nettype none

module vid_stream_out (
	input  logic           i_clk,
	input  logic           i_reset,
	input  logic           i_pix_valid,
	input  vid_pkg::pixel_t i_pixel,
	input  vid_pkg::cnt_t  i_hpos,
	input  vid_pkg::cnt_t  i_vpos,
	input  vid_pkg::dim_t  i_width,
	input  vid_pkg::dim_t  i_height,
	output logic           o_tvalid,
	output logic           o_tlast,
	output logic           o_tuser,
	output vid_pkg::pixel_t o_tdata
);

	import vid_pkg::*;

	logic at_last_col;
	logic at_last_row;

	// Positions count from zero for the current pixel
	assign at_last_col = (i_hpos == ({1'b0, i_width} - cnt_t'(1)));
	assign at_last_row = (i_vpos == ({1'b0, i_height} - cnt_t'(1)));

	////////////////////
	// Output registers
	////////////////////

	// Pixel data passes straight through the register
	always_ff @(posedge i_clk)
		o_tdata <= i_pixel;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_tvalid <= 1'b0;
			o_tuser  <= 1'b0;
			o_tlast  <= 1'b0;
		end
		else
		begin
			o_tvalid <= i_pix_valid;
			// End of line
			o_tuser  <= i_pix_valid && at_last_col;
			// End of frame, last pixel of the last active line
			o_tlast  <= i_pix_valid && at_last_col && at_last_row;
		end
	end

endmodule

`default_nettype wire

//--- vid_sync2stream.sv
/*
 * Raster video to pixel stream converter, top level
 * Measures the incoming video mode, reports lock, and forwards
 * the pixels as a stream with line and frame marks
 */
`timescale 1ns/1ps
`default_nettype none

module vid_sync2stream (
	input  logic            i_clk,
	input  logic            i_reset,
	// Raster input
	input  logic            i_pix_valid,
	input  logic            i_hsync,
	input  logic            i_vsync,
	input  vid_pkg::pixel_t i_pixel,
	// Pixel stream
	output logic            o_tvalid,
	output vid_pkg::pixel_t o_tdata,
	output logic            o_tlast,
	output logic            o_tuser,
	// Measured mode
	output vid_pkg::dim_t   o_width,
	output vid_pkg::dim_t   o_raw_width,
	output vid_pkg::dim_t   o_height,
	output vid_pkg::dim_t   o_raw_height,
	output logic            o_hsync_pol,
	output logic            o_vsync_pol,
	output logic            o_locked
);

	logic          row_start;
	logic          row_meas;
	logic          line_start;
	logic          frame_start;
	logic          line_had_pixels;
	logic          pix_in_row;
	vid_pkg::cnt_t h_total;
	vid_pkg::cnt_t h_active;
	vid_pkg::cnt_t v_total;
	vid_pkg::cnt_t v_active;
	logic          h_same;
	logic          h_differ;
	logic          v_same;
	logic          v_differ;

	////////////////////
	// Sync events
	////////////////////

	vid_sync_detect u_sync (
		.i_clk             (i_clk),
		.i_reset           (i_reset),
		.i_pix_valid       (i_pix_valid),
		.i_hsync           (i_hsync),
		.i_vsync           (i_vsync),
		.o_row_start       (row_start),
		.o_row_meas        (row_meas),
		.o_line_start      (line_start),
		.o_frame_start     (frame_start),
		.o_line_had_pixels (line_had_pixels),
		.o_pix_in_row      (pix_in_row),
		.o_hpol            (o_hsync_pol),
		.o_vpol            (o_vsync_pol)
	);

	////////////////////
	// Counters and captures
	////////////////////

	// Clocks per row, every clock steps
	vid_span_counter u_hcount (
		.i_clk     (i_clk),
		.i_restart (row_start),
		.i_step    (1'b1),
		.i_active  (pix_in_row),
		.o_total   (h_total),
		.o_active  (h_active)
	);

	// Lines per frame, frame_start only comes with line_start
	vid_span_counter u_vcount (
		.i_clk     (i_clk),
		.i_restart (frame_start),
		.i_step    (line_start),
		.i_active  (line_had_pixels),
		.o_total   (v_total),
		.o_active  (v_active)
	);

	vid_mode_capture u_hcap (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_capture (row_meas),
		.i_active  (h_active),
		.i_total   (h_total),
		.o_active  (o_width),
		.o_total   (o_raw_width),
		.o_same    (h_same),
		.o_differ  (h_differ)
	);

	vid_mode_capture u_vcap (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_capture (frame_start),
		.i_active  (v_active),
		.i_total   (v_total),
		.o_active  (o_height),
		.o_total   (o_raw_height),
		.o_same    (v_same),
		.o_differ  (v_differ)
	);

	vid_lock_fsm u_lock (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_h_same   (h_same),
		.i_h_differ (h_differ),
		.i_v_same   (v_same),
		.i_v_differ (v_differ),
		.o_locked   (o_locked)
	);

	// Stream follows the input by one clock
	vid_stream_out u_stream (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_pix_valid (i_pix_valid),
		.i_pixel     (i_pixel),
		.i_hpos      (h_active),
		.i_vpos      (v_active),
		.i_width     (o_width),
		.i_height    (o_height),
		.o_tvalid    (o_tvalid),
		.o_tlast     (o_tlast),
		.o_tuser     (o_tuser),
		.o_tdata     (o_tdata)
	);

endmodule

`default_nettype wire

//--- tb_sync2stream.sv
/*
 * Testbench for the sync-to-stream converter
 * Random rasters from a fixed seed, a reference model of the
 * measured mode, one-clock checks of the pixel stream and of
 * the line and frame marks once the mode is locked
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sync2stream;

	import vid_pkg::*;

	// Expected stream output for one input clock
	typedef struct packed {
		logic   valid;
		pixel_t data;
		logic   eol;
		logic   eof;
	} exp_t;

	logic   i_clk;
	logic   i_reset;
	logic   i_pix_valid;
	logic   i_hsync;
	logic   i_vsync;
	pixel_t i_pixel;
	logic   o_tvalid;
	pixel_t o_tdata;
	logic   o_tlast;
	logic   o_tuser;
	dim_t   o_width;
	dim_t   o_raw_width;
	dim_t   o_height;
	dim_t   o_raw_height;
	logic   o_hsync_pol;
	logic   o_vsync_pol;
	logic   o_locked;

	// Raster currently driven, clocks and lines
	int   width;
	int   hfront;
	int   hsync_len;
	int   hback;
	int   height;
	int   vfront;
	int   vsync_len;
	int   vback;
	// Inactive sync levels, which are also the expected polarities
	logic hs_idle;
	logic vs_idle;

	exp_t        exp_q[$];
	logic        check_marks;
	logic        lock_seen;
	logic        unlock_seen;

	initial
		i_clk = 1'b0;
	always #5 i_clk = ~i_clk;

	vid_sync2stream i_vid_sync2stream (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_pix_valid  (i_pix_valid),
		.i_hsync      (i_hsync),
		.i_vsync      (i_vsync),
		.i_pixel      (i_pixel),
		.o_tvalid     (o_tvalid),
		.o_tdata      (o_tdata),
		.o_tlast      (o_tlast),
		.o_tuser      (o_tuser),
		.o_width      (o_width),
		.o_raw_width  (o_raw_width),
		.o_height     (o_height),
		.o_raw_height (o_raw_height),
		.o_hsync_pol  (o_hsync_pol),
		.o_vsync_pol  (o_vsync_pol),
		.o_locked     (o_locked)
	);

	////////////////////
	// Checks
	////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_dim(input string what, input dim_t got, input dim_t exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// Mode outputs against the raster model
	task automatic check_mode();
		check_dim("o_width", o_width, dim_t'(width));
		check_dim("o_raw_width", o_raw_width, dim_t'(width + hfront + hsync_len + hback));
		check_dim("o_height", o_height, dim_t'(height));
		check_dim("o_raw_height", o_raw_height,
			dim_t'(height + vfront + vsync_len + vback));
		check_flag("o_hsync_pol", o_hsync_pol, hs_idle);
		check_flag("o_vsync_pol", o_vsync_pol, vs_idle);
	endtask

	task automatic check_reset_state();
		check_flag("o_locked after reset", o_locked, 1'b0);
		check_flag("o_tuser after reset", o_tuser, 1'b0);
		check_flag("o_tlast after reset", o_tlast, 1'b0);
		check_flag("o_tvalid after reset", o_tvalid, 1'b0);
		check_dim("o_width after reset", o_width, '0);
		check_dim("o_raw_width after reset", o_raw_width, '0);
		check_dim("o_height after reset", o_height, '0);
		check_dim("o_raw_height after reset", o_raw_height, '0);
	endtask

	// Output of the previous clock, then lock tracking
	task automatic check_outputs();
		exp_t want;
		if (exp_q.size() > 0)
		begin
			want = exp_q.pop_front();
			check_flag("o_tvalid", o_tvalid, want.valid);
			if (want.valid)
				check_pixel("o_tdata", o_tdata, want.data);
			// Marks only mean something with the sizes settled
			if (check_marks)
			begin
				check_flag("o_tuser", o_tuser, want.eol);
				check_flag("o_tlast", o_tlast, want.eof);
			end
		end
		if (!o_locked)
		begin
			if (check_marks)
				fail_run("Lock was lost while the raster stayed the same");
			unlock_seen = 1'b1;
		end
		else if (unlock_seen && !lock_seen)
		begin
			lock_seen   = 1'b1;
			check_marks = 1'b1;
		end
		if (check_marks)
			check_mode();
	endtask

	////////////////////
	// Raster generator
	////////////////////

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	// New raster, width forced to differ from the old one if given
	task automatic pick_raster(input int old_width);
		if (old_width >= 4)
			width = 4 + (old_width - 4 + rand_range(1, 16)) % 17;
		else
			width = rand_range(4, 20);
		hfront    = rand_range(2, 6);
		hsync_len = rand_range(2, 5);
		hback     = rand_range(3, 8);
		height    = rand_range(2, 8);
		vfront    = rand_range(1, 3);
		vsync_len = rand_range(1, 3);
		vback     = rand_range(1, 3);
		hs_idle   = (rand_range(0, 1) == 1);
		vs_idle   = (rand_range(0, 1) == 1);
	endtask

	// One input clock, driven on the falling edge
	task automatic drive_clock(input logic valid, input logic hs_on, input logic vs_on,
		input int col, input int row);
		exp_t   want;
		pixel_t pix;
		@(negedge i_clk);
		check_outputs();
		pix         = valid ? pixel_t'($urandom) : '0;
		i_pix_valid = valid;
		i_hsync     = hs_on ? ~hs_idle : hs_idle;
		i_vsync     = vs_on ? ~vs_idle : vs_idle;
		i_pixel     = pix;
		want.valid  = valid;
		want.data   = pix;
		want.eol    = valid && (col == width - 1);
		want.eof    = want.eol && (row == height - 1);
		exp_q.push_back(want);
	endtask

	// Active or blank span, front porch, hsync pulse, back porch
	task automatic send_line(input int row);
		logic active;
		logic vs_on;
		int   c;
		active = (row < height);
		vs_on  = (row >= height + vfront) && (row < height + vfront + vsync_len);
		for (c = 0; c < width; c++)
			drive_clock(active, 1'b0, vs_on, c, row);
		for (c = 0; c < hfront; c++)
			drive_clock(1'b0, 1'b0, vs_on, -1, row);
		for (c = 0; c < hsync_len; c++)
			drive_clock(1'b0, 1'b1, vs_on, -1, row);
		for (c = 0; c < hback; c++)
			drive_clock(1'b0, 1'b0, vs_on, -1, row);
	endtask

	task automatic send_frame(input logic watch_drop);
		int row;
		for (row = 0; row < height + vfront + vsync_len + vback; row++)
		begin
			send_line(row);
			// New width must be noticed by the end of the second line
			if (watch_drop && (row == 1) && !unlock_seen)
				fail_run("Lock did not drop within two lines of a new raster");
		end
	endtask

	// Wait for lock, five frames at most
	task automatic run_until_locked(input logic after_change);
		int frames;
		frames = 0;
		while (!lock_seen && (frames < 5))
		begin
			send_frame(after_change && (frames == 0));
			frames++;
		end
		if (!lock_seen)
			fail_run("Lock was not reached within five frames");
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial
	begin
		void'($urandom(32'h06a86924));
		check_marks = 1'b0;
		lock_seen   = 1'b0;
		unlock_seen = 1'b1;
		pick_raster(0);
		i_reset     = 1'b1;
		i_pix_valid = 1'b0;
		i_hsync     = hs_idle;
		i_vsync     = vs_idle;
		i_pixel     = '0;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b0;
		check_reset_state();

		// First raster, lock and hold
		run_until_locked(1'b0);
		send_frame(1'b0);
		send_frame(1'b0);

		// Different width, lock drops and comes back
		pick_raster(width);
		check_marks = 1'b0;
		lock_seen   = 1'b0;
		unlock_seen = 1'b0;
		run_until_locked(1'b1);
		send_frame(1'b0);
		send_frame(1'b0);

		// Last driven clock still owes its output
		@(negedge i_clk);
		check_outputs();

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
vid_pkg.sv
vid_sync_detect.sv
vid_span_counter.sv
vid_mode_capture.sv
vid_lock_fsm.sv
vid_stream_out.sv
vid_sync2stream.sv
tb_sync2stream.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_sync2stream \
	-f tb.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; }
echo "FAIL: simulation ended without a result"
exit 1
